// ==== include/mac_defs.svh ====
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// ==================================================
// floppy image geometry
// ==================================================

// image sizes in 16-bit words, taken from the final download address
// 800k double-sided image
`define MAC_DS_WORDS 409600
// 400k single-sided image
`define MAC_SS_WORDS 204800

// download indexes of the two floppy drives
`define MAC_IDX_INT 8'd1
`define MAC_IDX_EXT 8'd2

// ==================================================
// timing
// ==================================================

// clean clk8 strobes before the machine leaves reset
`define MAC_RST_TICKS 15
// clk_sys cycles a disk access keeps the activity LED lit
`define MAC_ACT_HOLD 500000

// ==================================================
// address map
// ==================================================

// sdram prefix shared by rom and download space
`define MAC_HI_BANK 4'd1
// a23..a21 of the autovector i/o space
`define MAC_IO_HI 3'd7
// function code of an interrupt acknowledge cycle
`define MAC_FC_IACK 4'd7

`endif

// ==== src/mac_pkg.sv ====
package mac_pkg;

	// ==================================================
	// data and address widths
	// ==================================================

	// one 16-bit bus word
	typedef logic [15:0] word_t;

	// byte address as delivered by the host loader
	typedef logic [24:0] ioctl_addr_t;

	// word address inside the download window
	typedef logic [20:0] dio_addr_t;

	// byte address from the address controller
	typedef logic [21:0] mem_addr_t;

	// word address on the sdram request port
	typedef logic [24:0] sdram_addr_t;

	// ==================================================
	// configuration and drive masks
	// ==================================================

	// cpu model selector, 0 is the plain 68000
	typedef logic [1:0] cpu_sel_t;

	// one bit per floppy drive, bit 0 internal
	typedef logic [1:0] drive_t;

	// reset sequencer states
	typedef enum logic [1:0] {
		RST_HOLD,
		RST_COUNT,
		RST_RUN
	} rst_state_t;

endpackage

// ==== src/mac_reset_seq.sv ====
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_reset_seq #(
	parameter int unsigned RST_TICKS = `MAC_RST_TICKS
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              clk8_en,
	input  logic              pll_locked,
	input  logic              reset_req,
	input  logic              cpu_reset_out_n,
	input  logic              cfg_ram_4mb_in,
	input  logic              cfg_model_se_in,
	input  mac_pkg::cpu_sel_t cfg_cpu_in,
	output logic              sys_rst_n,
	output logic              cfg_ram_4mb,
	output logic              cfg_model_se,
	output mac_pkg::cpu_sel_t cfg_cpu
);
	import mac_pkg::*;

	localparam int CNT_W = $clog2(RST_TICKS + 1);

	rst_state_t       state;
	logic [CNT_W-1:0] cnt;
	logic             rst_src;

	// any of these keeps the machine in reset
	assign rst_src = ~pll_locked | reset_req | ~cpu_reset_out_n;

	// sequencer only advances on clk8 strobes
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state        <= RST_HOLD;
			cnt          <= CNT_W'(RST_TICKS);
			cfg_ram_4mb  <= 1'b0;
			cfg_model_se <= 1'b0;
			cfg_cpu      <= '0;
		end else if (clk8_en) begin
			if (rst_src) begin
				// reload, count restarts once the source goes away
				state <= RST_HOLD;
				cnt   <= CNT_W'(RST_TICKS);
			end else if (cnt != '0) begin
				state        <= RST_COUNT;
				cnt          <= cnt - 1'b1;
				// config follows the osd until the count expires
				cfg_ram_4mb  <= cfg_ram_4mb_in;
				cfg_model_se <= cfg_model_se_in;
				cfg_cpu      <= cfg_cpu_in;
			end else begin
				state <= RST_RUN;
			end
		end
	end

	assign sys_rst_n = (state == RST_RUN);

endmodule

// ==== src/mac_dl_bridge.sv ====
`timescale 1ns/1ps

module mac_dl_bridge (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 ioctl_wr,
	input  mac_pkg::ioctl_addr_t ioctl_addr,
	input  mac_pkg::word_t       ioctl_data,
	input  logic [7:0]           ioctl_index,
	input  logic                 dio_bus_ctrl,
	output logic                 ioctl_wait,
	output logic                 dio_write,
	output mac_pkg::dio_addr_t   dio_addr,
	output mac_pkg::word_t       dio_data
);
	import mac_pkg::*;

	dio_addr_t map_addr;
	logic      bus_ctrl_d;
	logic      phase_end;

	// ==================================================
	// address mapping
	// ==================================================

	// host counts bytes, sdram counts words, so bit 0 is dropped
	// floppy images sit above the rom at word 0x80000 and 0x100000
	// index 0 with bit 6 selects the upper rom half
	always_comb begin
		if (ioctl_index[1:0] != 2'b00) begin
			map_addr = {ioctl_index[1:0], ioctl_addr[19:1]};
		end else begin
			map_addr = {2'b00, ioctl_index[6], ioctl_addr[18:1]};
		end
	end

	// capture register
	// a new host write overwrites whatever is pending
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			// host sends little endian, 68k wants big endian
			dio_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			dio_addr <= map_addr;
		end
	end

	// ==================================================
	// wait handshake
	// ==================================================

	// bus slot just handed back to the cpu with a write in it
	assign phase_end = bus_ctrl_d & ~dio_bus_ctrl & dio_write;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_wait <= 1'b0;
			dio_write  <= 1'b0;
			bus_ctrl_d <= 1'b0;
		end else begin
			bus_ctrl_d <= dio_bus_ctrl;
			// write request only changes outside the download slot
			if (!dio_bus_ctrl) begin
				dio_write <= ioctl_wait;
			end
			if (phase_end) begin
				ioctl_wait <= 1'b0;
			end else if (ioctl_wr) begin
				ioctl_wait <= 1'b1;
			end
		end
	end

endmodule

// ==== src/mac_floppy_detect.sv ====
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_floppy_detect #(
	parameter int unsigned ACT_HOLD = `MAC_ACT_HOLD
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  mac_pkg::ioctl_addr_t ioctl_addr,
	input  mac_pkg::drive_t      disk_eject,
	input  mac_pkg::drive_t      disk_act,
	input  mac_pkg::drive_t      disk_motor,
	output mac_pkg::drive_t      disk_inserted,
	output mac_pkg::drive_t      disk_double_sided,
	output logic                 led_user
);
	import mac_pkg::*;

	localparam int HOLD_W = $clog2(ACT_HOLD + 1);

	drive_t            ds_q;
	drive_t            ins_q;
	drive_t            upd;
	logic              dl_d;
	logic              dl_fall;
	logic              img_ds;
	logic              img_ss;
	logic [HOLD_W-1:0] hold_cnt;
	logic              act_q;

	// ==================================================
	// image classification
	// ==================================================

	assign dl_fall = dl_d & ~ioctl_download;
	// last word address equals the image size in words
	assign img_ds  = (ioctl_addr[24:1] == 24'(`MAC_DS_WORDS));
	assign img_ss  = (ioctl_addr[24:1] == 24'(`MAC_SS_WORDS));
	assign upd[0]  = dl_fall & (ioctl_index == `MAC_IDX_INT);
	assign upd[1]  = dl_fall & (ioctl_index == `MAC_IDX_EXT);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_d  <= 1'b0;
			ds_q  <= '0;
			ins_q <= '0;
		end else begin
			dl_d <= ioctl_download;
			for (int i = 0; i < 2; i++) begin
				// eject from the os wins over a finishing download
				if (disk_eject[i]) begin
					ds_q[i]  <= 1'b0;
					ins_q[i] <= 1'b0;
				end else if (upd[i]) begin
					ds_q[i]  <= img_ds;
					ins_q[i] <= img_ds | img_ss;
				end
			end
		end
	end

	// unknown sizes leave both flags clear, drive reads as empty
	assign disk_inserted     = ins_q;
	assign disk_double_sided = ds_q;

	// ==================================================
	// activity led
	// ==================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt <= '0;
			act_q    <= 1'b0;
		end else begin
			act_q <= (hold_cnt != '0);
			// any access restarts the hold window
			if (|disk_act) begin
				hold_cnt <= HOLD_W'(ACT_HOLD);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	// led blinks against the motor while data moves
	assign led_user = ioctl_download | (act_q ^ (|disk_motor));

endmodule

// ==== src/mac_mem_arbiter.sv ====
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_mem_arbiter (
	input  logic                 ioctl_download,
	input  logic                 dio_bus_ctrl,
	input  logic                 dio_write,
	input  mac_pkg::dio_addr_t   dio_addr,
	input  mac_pkg::word_t       dio_data,
	input  logic                 rom_oe_n,
	input  logic                 ram_oe_n,
	input  logic                 ram_we_n,
	input  logic                 mem_uds_n,
	input  logic                 mem_lds_n,
	input  mac_pkg::mem_addr_t   mem_addr,
	input  mac_pkg::word_t       mem_wdata,
	input  mac_pkg::drive_t      dsk_ack,
	input  logic                 cfg_model_se,
	input  mac_pkg::word_t       sdram_rdata,
	output mac_pkg::sdram_addr_t sdram_addr,
	output mac_pkg::word_t       sdram_wdata,
	output logic [1:0]           sdram_be,
	output logic                 sdram_we,
	output logic                 sdram_oe,
	output mac_pkg::word_t       cpu_rdata
);
	import mac_pkg::*;

	logic  dl_cycle;
	logic  dsk_rd;
	word_t dsk_byte;

	// download owns the port only inside its own bus slot
	assign dl_cycle = ioctl_download & dio_bus_ctrl;
	// either drive fetching from its image
	assign dsk_rd   = |dsk_ack;

	// ==================================================
	// request mux
	// ==================================================

	always_comb begin
		if (dl_cycle) begin
			sdram_addr = {`MAC_HI_BANK, dio_addr};
		end else if (!rom_oe_n) begin
			// plus and se roms live side by side in the high bank
			sdram_addr = {`MAC_HI_BANK, 2'b00, cfg_model_se, mem_addr[18:1]};
		end else begin
			// ram below, disk images in the upper 4M words
			sdram_addr = {3'b000, dsk_rd, mem_addr[21:1]};
		end
	end

	assign sdram_wdata = dl_cycle ? dio_data : mem_wdata;
	// download always writes whole words
	assign sdram_be    = dl_cycle ? 2'b11 : {~mem_uds_n, ~mem_lds_n};
	assign sdram_we    = dl_cycle ? dio_write : ~ram_we_n;
	assign sdram_oe    = dl_cycle ? 1'b0 : (~ram_oe_n | ~rom_oe_n | dsk_rd);

	// ==================================================
	// read return
	// ==================================================

	// disk controller expects bytes, pick one and copy it to both lanes
	assign dsk_byte = mem_addr[0] ? {2{sdram_rdata[7:0]}} : {2{sdram_rdata[15:8]}};

	always_comb begin
		if (dl_cycle) begin
			// all ones keeps the screen black while loading
			cpu_rdata = 16'hffff;
		end else if (dsk_rd) begin
			cpu_rdata = dsk_byte;
		end else begin
			cpu_rdata = sdram_rdata;
		end
	end

endmodule

// ==== src/mac_bus_ctrl.sv ====
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_bus_ctrl (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       sys_rst_n,
	input  logic       cpu_as_n,
	input  logic [3:0] cpu_fc,
	input  logic [2:0] cpu_addr_hi,
	input  logic       cpu_bus_ctrl,
	input  logic       sel_rom,
	input  logic       sel_ram,
	input  logic       turbo,
	output logic       vpa_n,
	output logic       dtack_n
);
	logic io_space;
	logic bus_ctrl_d;
	logic bus_ctrl_rise;
	logic turbo_dtack_en;

	// top 2M of the 68k map, peripherals answer with vpa
	assign io_space      = (cpu_addr_hi == `MAC_IO_HI);
	assign bus_ctrl_rise = ~bus_ctrl_d & cpu_bus_ctrl;

	// ==================================================
	// vpa and dtack
	// ==================================================

	// interrupt acknowledge is autovectored
	assign vpa_n   = ~((cpu_fc == `MAC_FC_IACK) | (~cpu_as_n & io_space));
	// in turbo the cpu can run ahead of its memory slot
	// so dtack waits for the enable
	assign dtack_n = ~(~cpu_as_n & ~io_space & (~turbo | turbo_dtack_en));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bus_ctrl_d     <= 1'b0;
			turbo_dtack_en <= 1'b0;
		end else begin
			bus_ctrl_d <= cpu_bus_ctrl;
			if (!sys_rst_n || cpu_as_n) begin
				turbo_dtack_en <= 1'b0;
			end else if (bus_ctrl_rise || (!sel_rom && !sel_ram)) begin
				// slot arrived, or no memory behind this access
				turbo_dtack_en <= 1'b1;
			end
		end
	end

endmodule

// ==== src/mac_core_top.sv ====
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_core_top #(
	parameter int unsigned RST_TICKS = `MAC_RST_TICKS,
	parameter int unsigned ACT_HOLD  = `MAC_ACT_HOLD
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	// reset and configuration
	input  logic                 clk8_en,
	input  logic                 pll_locked,
	input  logic                 reset_req,
	input  logic                 cpu_reset_out_n,
	input  logic                 cfg_ram_4mb_in,
	input  logic                 cfg_model_se_in,
	input  mac_pkg::cpu_sel_t    cfg_cpu_in,
	output logic                 sys_rst_n,
	output logic                 cfg_ram_4mb,
	output logic                 cfg_model_se,
	output mac_pkg::cpu_sel_t    cfg_cpu,
	// host download
	input  logic                 ioctl_download,
	input  logic                 ioctl_wr,
	input  mac_pkg::ioctl_addr_t ioctl_addr,
	input  mac_pkg::word_t       ioctl_data,
	input  logic [7:0]           ioctl_index,
	input  logic                 dio_bus_ctrl,
	output logic                 ioctl_wait,
	// floppy
	input  mac_pkg::drive_t      disk_eject,
	input  mac_pkg::drive_t      disk_act,
	input  mac_pkg::drive_t      disk_motor,
	output mac_pkg::drive_t      disk_inserted,
	output mac_pkg::drive_t      disk_double_sided,
	output logic                 led_user,
	// memory cycles from the address controller
	input  logic                 rom_oe_n,
	input  logic                 ram_oe_n,
	input  logic                 ram_we_n,
	input  logic                 mem_uds_n,
	input  logic                 mem_lds_n,
	input  mac_pkg::mem_addr_t   mem_addr,
	input  mac_pkg::word_t       mem_wdata,
	input  mac_pkg::drive_t      dsk_ack,
	input  mac_pkg::word_t       sdram_rdata,
	output mac_pkg::sdram_addr_t sdram_addr,
	output mac_pkg::word_t       sdram_wdata,
	output logic [1:0]           sdram_be,
	output logic                 sdram_we,
	output logic                 sdram_oe,
	output mac_pkg::word_t       cpu_rdata,
	// cpu bus
	input  logic                 cpu_as_n,
	input  logic [3:0]           cpu_fc,
	input  logic [2:0]           cpu_addr_hi,
	input  logic                 cpu_bus_ctrl,
	input  logic                 sel_rom,
	input  logic                 sel_ram,
	input  logic                 turbo,
	output logic                 vpa_n,
	output logic                 dtack_n
);
	import mac_pkg::*;

	// download bridge to arbiter
	logic      dio_write;
	dio_addr_t dio_addr;
	word_t     dio_data;

	mac_reset_seq #(.RST_TICKS(RST_TICKS)) i_reset_seq (
		.clk_sys, .rst_n, .clk8_en, .pll_locked, .reset_req, .cpu_reset_out_n,
		.cfg_ram_4mb_in, .cfg_model_se_in, .cfg_cpu_in,
		.sys_rst_n, .cfg_ram_4mb, .cfg_model_se, .cfg_cpu
	);

	mac_dl_bridge i_dl_bridge (
		.clk_sys, .rst_n, .ioctl_wr, .ioctl_addr, .ioctl_data, .ioctl_index,
		.dio_bus_ctrl, .ioctl_wait, .dio_write, .dio_addr, .dio_data
	);

	mac_floppy_detect #(.ACT_HOLD(ACT_HOLD)) i_floppy_detect (
		.clk_sys, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr,
		.disk_eject, .disk_act, .disk_motor,
		.disk_inserted, .disk_double_sided, .led_user
	);

	// purely combinational, same cycle as the request
	mac_mem_arbiter i_mem_arbiter (
		.ioctl_download, .dio_bus_ctrl, .dio_write, .dio_addr, .dio_data,
		.rom_oe_n, .ram_oe_n, .ram_we_n, .mem_uds_n, .mem_lds_n,
		.mem_addr, .mem_wdata, .dsk_ack, .cfg_model_se, .sdram_rdata,
		.sdram_addr, .sdram_wdata, .sdram_be, .sdram_we, .sdram_oe, .cpu_rdata
	);

	mac_bus_ctrl i_bus_ctrl (
		.clk_sys, .rst_n, .sys_rst_n, .cpu_as_n, .cpu_fc, .cpu_addr_hi,
		.cpu_bus_ctrl, .sel_rom, .sel_ram, .turbo, .vpa_n, .dtack_n
	);

endmodule

// ==== dv/mac_core_sva.sv ====
`timescale 1ns/1ps

module mac_core_sva (
	input logic            clk_sys,
	input logic            rst_n,
	input logic            sdram_we,
	input logic            sdram_oe,
	input mac_pkg::drive_t disk_inserted,
	input mac_pkg::drive_t disk_double_sided,
	input logic            ioctl_wait,
	input logic            dio_bus_ctrl
);

	// ==================================================
	// sdram port and floppy flags
	// ==================================================

	// one direction per sdram request
	we_oe_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sdram_we && sdram_oe))
		else $error("sdram_we and sdram_oe high in the same cycle");

	// a double-sided drive is always an inserted drive
	ds_implies_inserted: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(disk_double_sided & ~disk_inserted) == 2'b00)
		else $error("double-sided flag set on an empty drive");

	// ==================================================
	// download handshake
	// ==================================================

	// wait only drops right after the download slot closes
	wait_falls_after_slot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(ioctl_wait) |-> ($past(!dio_bus_ctrl) && $past(dio_bus_ctrl, 2)))
		else $error("ioctl_wait fell without a preceding dio_bus_ctrl fall");

endmodule

bind mac_core_top mac_core_sva i_sva (
	.clk_sys           (clk_sys),
	.rst_n             (rst_n),
	.sdram_we          (sdram_we),
	.sdram_oe          (sdram_oe),
	.disk_inserted     (disk_inserted),
	.disk_double_sided (disk_double_sided),
	.ioctl_wait        (ioctl_wait),
	.dio_bus_ctrl      (dio_bus_ctrl)
);

// ==== dv/tb_mac_core.sv ====
`timescale 1ns/1ps
`include "mac_defs.svh"

module tb_mac_core;
	import mac_pkg::*;

	localparam int CLK_PERIOD = 20;
	// short reset and led hold keep the run small
	localparam int TB_RST_TICKS = 3;
	localparam int TB_ACT_HOLD  = 40;
	// cycle budget per test, summed for the watchdog
	localparam int RESET_CYCLES  = 40;
	localparam int DL_CYCLES     = 40;
	localparam int FLOPPY_CYCLES = 80 + TB_ACT_HOLD;
	localparam int ARB_CYCLES    = 60;
	localparam int BUS_CYCLES    = 40;
	localparam int MARGIN_CYCLES = 100;
	localparam int RUN_CYCLES    = RESET_CYCLES + DL_CYCLES + FLOPPY_CYCLES
		+ ARB_CYCLES + BUS_CYCLES + MARGIN_CYCLES;

	logic        clk_sys;
	logic        rst_n;
	logic        clk8_en;
	logic        pll_locked;
	logic        reset_req;
	logic        cpu_reset_out_n;
	logic        cfg_ram_4mb_in;
	logic        cfg_model_se_in;
	cpu_sel_t    cfg_cpu_in;
	logic        sys_rst_n;
	logic        cfg_ram_4mb;
	logic        cfg_model_se;
	cpu_sel_t    cfg_cpu;
	logic        ioctl_download;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	word_t       ioctl_data;
	logic [7:0]  ioctl_index;
	logic        dio_bus_ctrl;
	logic        ioctl_wait;
	drive_t      disk_eject;
	drive_t      disk_act;
	drive_t      disk_motor;
	drive_t      disk_inserted;
	drive_t      disk_double_sided;
	logic        led_user;
	logic        rom_oe_n;
	logic        ram_oe_n;
	logic        ram_we_n;
	logic        mem_uds_n;
	logic        mem_lds_n;
	mem_addr_t   mem_addr;
	word_t       mem_wdata;
	drive_t      dsk_ack;
	word_t       sdram_rdata;
	sdram_addr_t sdram_addr;
	word_t       sdram_wdata;
	logic [1:0]  sdram_be;
	logic        sdram_we;
	logic        sdram_oe;
	word_t       cpu_rdata;
	logic        cpu_as_n;
	logic [3:0]  cpu_fc;
	logic [2:0]  cpu_addr_hi;
	logic        cpu_bus_ctrl;
	logic        sel_rom;
	logic        sel_ram;
	logic        turbo;
	logic        vpa_n;
	logic        dtack_n;

	logic [31:0] lfsr_state;
	// model of the floppy flags
	drive_t      exp_ins;
	drive_t      exp_ds;
	// address of the last host write, still held in the bridge
	sdram_addr_t last_dl_addr;

	mac_core_top #(.RST_TICKS(TB_RST_TICKS), .ACT_HOLD(TB_ACT_HOLD)) i_dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ==================================================
	// helpers
	// ==================================================

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_sdram_addr(input sdram_addr_t got, input sdram_addr_t exp,
		input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_drive(input drive_t got, input drive_t exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_cpu_sel(input cpu_sel_t got, input cpu_sel_t exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	// ==================================================
	// reset sequencer
	// ==================================================

	// one clk8 strobe, one clk_sys cycle wide
	task automatic strobe_clk8();
		@(negedge clk_sys);
		clk8_en = 1'b1;
		@(negedge clk_sys);
		clk8_en = 1'b0;
	endtask

	// hold through reset_req, then count clean strobes until release
	task automatic run_reset_seq(input logic se, input logic ram4, input cpu_sel_t cpu);
		reset_req = 1'b1;
		strobe_clk8();
		check_bit(sys_rst_n, 1'b0, "sys_rst_n with reset_req");
		reset_req       = 1'b0;
		cfg_model_se_in = se;
		cfg_ram_4mb_in  = ram4;
		cfg_cpu_in      = cpu;
		for (int i = 1; i <= TB_RST_TICKS; i++) begin
			strobe_clk8();
			check_bit(sys_rst_n, 1'b0, $sformatf("sys_rst_n after strobe %0d", i));
		end
		strobe_clk8();
		check_bit(sys_rst_n, 1'b1, "sys_rst_n after last strobe");
		check_bit(cfg_model_se, se, "cfg_model_se latched");
		check_bit(cfg_ram_4mb, ram4, "cfg_ram_4mb latched");
		check_cpu_sel(cfg_cpu, cpu, "cfg_cpu latched");
	endtask

	task automatic test_reset();
		cpu_sel_t cpu;
		cpu = cpu_sel_t'(take_bits(2));
		check_bit(sys_rst_n, 1'b0, "sys_rst_n after power-on");
		run_reset_seq(1'b1, 1'b0, cpu);
		// running machine ignores the osd
		cfg_model_se_in = 1'b0;
		cfg_ram_4mb_in  = 1'b1;
		strobe_clk8();
		strobe_clk8();
		check_bit(sys_rst_n, 1'b1, "sys_rst_n stays released");
		check_bit(cfg_model_se, 1'b1, "cfg_model_se frozen");
		check_bit(cfg_ram_4mb, 1'b0, "cfg_ram_4mb frozen");
		run_reset_seq(1'b0, 1'b1, ~cpu);
	endtask

	// ==================================================
	// download bridge
	// ==================================================

	// poll ioctl_wait at the falling edge, bounded
	task automatic wait_ioctl_wait(input logic level);
		int n;
		n = 0;
		while (ioctl_wait !== level) begin
			if (n == 8) begin
				fail_run("ioctl_wait did not reach the expected level in time");
			end
			@(negedge clk_sys);
			n++;
		end
	endtask

	task automatic dl_write(input logic [7:0] idx);
		ioctl_addr_t addr;
		word_t       data;
		sdram_addr_t exp_addr;
		addr = ioctl_addr_t'(take_bits(25));
		data = word_t'(take_bits(16));
		// floppy indexes sit above 19 word bits, rom halves above 18
		if (idx[1:0] != 2'b00) begin
			exp_addr = {`MAC_HI_BANK, idx[1:0], addr[19:1]};
		end else begin
			exp_addr = {`MAC_HI_BANK, 2'b00, idx[6], addr[18:1]};
		end
		@(negedge clk_sys);
		ioctl_index = idx;
		ioctl_addr  = addr;
		ioctl_data  = data;
		ioctl_wr    = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_bit(ioctl_wait, 1'b1, "ioctl_wait one cycle after ioctl_wr");
		// request needs a cycle outside the slot to reach dio_write
		@(negedge clk_sys);
		dio_bus_ctrl = 1'b1;
		#1;
		check_sdram_addr(sdram_addr, exp_addr, "download sdram_addr");
		check_word(sdram_wdata, {data[7:0], data[15:8]}, "download sdram_wdata");
		check_bit(sdram_we, 1'b1, "download sdram_we");
		check_bit(sdram_oe, 1'b0, "download sdram_oe");
		check_bit(sdram_be[1], 1'b1, "download upper byte enable");
		check_bit(sdram_be[0], 1'b1, "download lower byte enable");
		check_bit(ioctl_wait, 1'b1, "ioctl_wait during bus phase");
		@(negedge clk_sys);
		dio_bus_ctrl = 1'b0;
		@(negedge clk_sys);
		wait_ioctl_wait(1'b0);
		last_dl_addr = exp_addr;
	endtask

	task automatic test_download();
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		dl_write(8'h01);
		dl_write(8'h02);
		dl_write(8'h40);
		dl_write(8'h00);
		// index 0 keeps the floppy flags out of it
		@(negedge clk_sys);
		ioctl_index    = 8'h00;
		ioctl_download = 1'b0;
	endtask

	// ==================================================
	// floppy detection
	// ==================================================

	task automatic eject_drive(input drive_t eject);
		@(negedge clk_sys);
		disk_eject = eject;
		@(negedge clk_sys);
		disk_eject = '0;
		exp_ins    = exp_ins & ~eject;
		exp_ds     = exp_ds & ~eject;
		check_drive(disk_inserted, exp_ins, "disk_inserted after eject");
		check_drive(disk_double_sided, exp_ds, "disk_double_sided after eject");
	endtask

	// image download for drive d whose last word address is words
	task automatic load_image(input int d, input int words, input drive_t eject);
		exp_ins = exp_ins & ~eject;
		exp_ds  = exp_ds & ~eject;
		if (!eject[d]) begin
			exp_ds[d]  = (words == `MAC_DS_WORDS);
			exp_ins[d] = (words == `MAC_DS_WORDS) || (words == `MAC_SS_WORDS);
		end
		@(negedge clk_sys);
		ioctl_index    = (d == 0) ? `MAC_IDX_INT : `MAC_IDX_EXT;
		ioctl_addr     = ioctl_addr_t'(words * 2);
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		check_bit(led_user, 1'b1, "led_user during download");
		ioctl_download = 1'b0;
		disk_eject     = eject;
		@(negedge clk_sys);
		disk_eject = '0;
		check_drive(disk_inserted, exp_ins, "disk_inserted after download");
		check_drive(disk_double_sided, exp_ds, "disk_double_sided after download");
	endtask

	task automatic test_floppy();
		exp_ins = '0;
		exp_ds  = '0;
		eject_drive(2'b11);
		load_image(0, `MAC_DS_WORDS, 2'b00);
		load_image(1, `MAC_SS_WORDS, 2'b00);
		load_image(1, `MAC_SS_WORDS + 1, 2'b00);
		eject_drive(2'b01);
		// eject at the download end wins
		load_image(0, `MAC_DS_WORDS, 2'b01);
		load_image(1, `MAC_SS_WORDS, 2'b00);
		// single access pulse, led then held for the hold time
		@(negedge clk_sys);
		ioctl_index = 8'h00;
		disk_act    = 2'b10;
		@(negedge clk_sys);
		disk_act = '0;
		@(negedge clk_sys);
		check_bit(led_user, 1'b1, "led_user while activity held");
		disk_motor = 2'b01;
		#1;
		check_bit(led_user, 1'b0, "led_user with activity and motor");
		@(negedge clk_sys);
		disk_motor = '0;
		repeat (TB_ACT_HOLD + 3) @(negedge clk_sys);
		check_bit(led_user, 1'b0, "led_user after hold expired");
		disk_motor = 2'b10;
		#1;
		check_bit(led_user, 1'b1, "led_user with motor only");
		@(negedge clk_sys);
		disk_motor = '0;
	endtask

	// ==================================================
	// memory arbiter
	// ==================================================

	task automatic arb_cycles(input logic se);
		mem_addr_t a;
		word_t     rd;
		word_t     wd;
		a  = mem_addr_t'(take_bits(22));
		rd = word_t'(take_bits(16));
		wd = word_t'(take_bits(16));
		@(negedge clk_sys);
		mem_addr    = a;
		sdram_rdata = rd;
		rom_oe_n    = 1'b0;
		#1;
		check_sdram_addr(sdram_addr, {`MAC_HI_BANK, 2'b00, se, a[18:1]}, "rom sdram_addr");
		check_bit(sdram_oe, 1'b1, "rom sdram_oe");
		check_word(cpu_rdata, rd, "rom cpu_rdata");
		@(negedge clk_sys);
		rom_oe_n = 1'b1;
		ram_oe_n = 1'b0;
		#1;
		check_sdram_addr(sdram_addr, {4'b0000, a[21:1]}, "ram read sdram_addr");
		check_word(cpu_rdata, rd, "ram cpu_rdata");
		@(negedge clk_sys);
		ram_oe_n  = 1'b1;
		ram_we_n  = 1'b0;
		mem_uds_n = 1'b0;
		mem_wdata = wd;
		#1;
		check_bit(sdram_we, 1'b1, "ram write sdram_we");
		check_bit(sdram_oe, 1'b0, "ram write sdram_oe");
		check_bit(sdram_be[1], 1'b1, "ram write upper byte enable");
		check_bit(sdram_be[0], 1'b0, "ram write lower byte enable");
		check_word(sdram_wdata, wd, "ram sdram_wdata");
		// disk fetch, odd address takes the low byte
		for (int b = 0; b < 2; b++) begin
			@(negedge clk_sys);
			ram_we_n  = 1'b1;
			mem_uds_n = 1'b1;
			dsk_ack   = (b == 0) ? 2'b01 : 2'b10;
			mem_addr  = {a[21:1], b[0]};
			#1;
			check_sdram_addr(sdram_addr, {4'b0001, a[21:1]}, "disk sdram_addr");
			check_word(cpu_rdata, (b == 0) ? {rd[15:8], rd[15:8]} : {rd[7:0], rd[7:0]},
				"disk byte");
		end
		@(negedge clk_sys);
		dsk_ack = '0;
	endtask

	task automatic test_arbiter();
		for (int se = 0; se < 2; se++) begin
			run_reset_seq(se[0], 1'b0, 2'd0);
			arb_cycles(se[0]);
		end
		// no request pending, slot still returns all ones
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		dio_bus_ctrl   = 1'b1;
		#1;
		check_word(cpu_rdata, 16'hffff, "cpu_rdata during download");
		check_sdram_addr(sdram_addr, last_dl_addr, "idle download sdram_addr");
		check_bit(sdram_we, 1'b0, "sdram_we without pending write");
		@(negedge clk_sys);
		dio_bus_ctrl   = 1'b0;
		ioctl_download = 1'b0;
	endtask

	// ==================================================
	// cpu bus control
	// ==================================================

	task automatic test_bus();
		int n;
		@(negedge clk_sys);
		cpu_fc = `MAC_FC_IACK;
		#1;
		check_bit(vpa_n, 1'b0, "vpa_n on interrupt acknowledge");
		@(negedge clk_sys);
		cpu_fc      = 4'd5;
		cpu_addr_hi = `MAC_IO_HI;
		cpu_as_n    = 1'b0;
		#1;
		check_bit(vpa_n, 1'b0, "vpa_n in i/o space");
		check_bit(dtack_n, 1'b1, "dtack_n in i/o space");
		@(negedge clk_sys);
		cpu_addr_hi = 3'd2;
		sel_ram     = 1'b1;
		#1;
		check_bit(vpa_n, 1'b1, "vpa_n in ram space");
		check_bit(dtack_n, 1'b0, "dtack_n with turbo off");
		// turbo, ram access waits for its slot
		@(negedge clk_sys);
		cpu_as_n = 1'b1;
		turbo    = 1'b1;
		@(negedge clk_sys);
		cpu_as_n = 1'b0;
		repeat (3) begin
			#1;
			check_bit(dtack_n, 1'b1, "turbo dtack_n before slot");
			@(negedge clk_sys);
		end
		cpu_bus_ctrl = 1'b1;
		#1;
		check_bit(dtack_n, 1'b1, "turbo dtack_n in the slot cycle");
		n = 0;
		while (dtack_n !== 1'b0) begin
			if (n == 4) begin
				fail_run("dtack_n never asserted in turbo mode after the slot");
			end
			@(negedge clk_sys);
			n++;
		end
		@(negedge clk_sys);
		cpu_bus_ctrl = 1'b0;
		cpu_as_n     = 1'b1;
		#1;
		check_bit(dtack_n, 1'b1, "dtack_n after address strobe");
	endtask

	// ==================================================
	// run
	// ==================================================

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		fail_run("timeout: the tests did not finish within the time limit");
	end

	initial begin
		lfsr_state      = 32'h5c62d627;
		clk_sys         = 1'b0;
		rst_n           = 1'b0;
		clk8_en         = 1'b0;
		pll_locked      = 1'b1;
		reset_req       = 1'b0;
		cpu_reset_out_n = 1'b1;
		cfg_ram_4mb_in  = 1'b0;
		cfg_model_se_in = 1'b0;
		cfg_cpu_in      = '0;
		ioctl_download  = 1'b0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		ioctl_index     = '0;
		dio_bus_ctrl    = 1'b0;
		disk_eject      = '0;
		disk_act        = '0;
		disk_motor      = '0;
		rom_oe_n        = 1'b1;
		ram_oe_n        = 1'b1;
		ram_we_n        = 1'b1;
		mem_uds_n       = 1'b1;
		mem_lds_n       = 1'b1;
		mem_addr        = '0;
		mem_wdata       = '0;
		dsk_ack         = '0;
		sdram_rdata     = '0;
		cpu_as_n        = 1'b1;
		cpu_fc          = '0;
		cpu_addr_hi     = '0;
		cpu_bus_ctrl    = 1'b0;
		sel_rom         = 1'b0;
		sel_ram         = 1'b0;
		turbo           = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		test_reset();
		test_download();
		test_floppy();
		test_arbiter();
		test_bus();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
src/mac_pkg.sv
src/mac_reset_seq.sv
src/mac_dl_bridge.sv
src/mac_floppy_detect.sv
src/mac_mem_arbiter.sv
src/mac_bus_ctrl.sv
src/mac_core_top.sv
dv/mac_core_sva.sv
dv/tb_mac_core.sv

// ==== Bender.yml ====
package:
  name: mac_core

export_include_dirs:
  - include

sources:
  - files:
      - src/mac_pkg.sv
      - src/mac_reset_seq.sv
      - src/mac_dl_bridge.sv
      - src/mac_floppy_detect.sv
      - src/mac_mem_arbiter.sv
      - src/mac_bus_ctrl.sv
      - src/mac_core_top.sv
  - target: test
    files:
      - dv/mac_core_sva.sv
      - dv/tb_mac_core.sv
